// ==== tb.f ====
+incdir+include
source/vcp_pkg.sv
source/vcp_ctrl.sv
source/vcp_vrf.sv
source/vcp_valu.sv
source/vcp_vlsu.sv
source/vcp_top.sv
dv/vcp_tb_clk.sv
dv/vcp_wb_mem.sv
dv/vcp_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = vcp_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/vcp_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// random instruction stream against an in-order model of the co-processor
// the model executes each instruction at its acceptance edge
// memory sits at byte base 0x1000, its image is copied once after reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "vcp_macros.svh"

module vcp_tb import vcp_pkg::*; ();

	localparam int          N_WORDS  = 64;
	localparam logic [31:0] MEM_BASE = 32'h0000_1000;
	localparam int          N_INSTR  = 54;                      // 4 + 20 + 6 + 24
	localparam int          WD_CYC   = N_INSTR * 4 * 40 + 100;  // plus reset and drains

	logic                   clk, rstn;
	logic                   valid, ready, alu_done, lsu_done;
	vcp_op_e                op;
	vreg_idx_t              vd, vs1, vs2;
	logic [`VCP_ADDR_W-1:0] rs1;
	vlen_t                  vl;
	logic                   wb_cyc, wb_stb, wb_we, wb_ack;
	logic [`VCP_ADDR_W-1:0] wb_adr;
	logic [`VCP_DATA_W-1:0] wb_dat_m, wb_dat_s; // master out, slave out

	logic [31:0] model_vrf [`VCP_NUM_VREGS][`VCP_NUM_ELEMS];
	logic [31:0] model_mem [N_WORDS];
	logic [31:0] exp_adr_q [$]; // expected Wishbone write stream
	logic [31:0] exp_dat_q [$];
	logic [31:0] lfsr_q;
	int          errors = 0;
	int          checks = 0;
	int          issued = 0;
	int          done_cnt = 0;

	vcp_tb_clk u_clk (.clk_o(clk), .rstn_o(rstn));

	vcp_wb_mem u_mem (
		.clk_i(clk), .rstn_i(rstn), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
		.wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_m),
		.wb_dat_o(wb_dat_s), .wb_ack_o(wb_ack)
	);

	vcp_top dut_i (
		.clk_i(clk), .rstn_i(rstn), .valid_i(valid), .op_i(op), .vd_i(vd),
		.vs1_i(vs1), .vs2_i(vs2), .rs1_i(rs1), .vl_i(vl), .ready_o(ready),
		.alu_done_o(alu_done), .lsu_done_o(lsu_done), .wb_cyc_o(wb_cyc),
		.wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_m),
		.wb_dat_i(wb_dat_s), .wb_ack_i(wb_ack)
	);

	////////////////////////////////////////////////////////////////////////////
	// random numbers and checking
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Fibonacci, taps 32 22 2 1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q); // one step per bit
			v      = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic int rand_word(input int len);
		int w;
		w = int'(rand_bits(6));
		if (w + len > N_WORDS) begin
			w = N_WORDS - len; // keep the vector inside memory
		end
		return w;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model and instruction driver
	////////////////////////////////////////////////////////////////////////////
	task automatic exec_model(input vcp_op_e o, input int d, input int s1, input int s2,
		input int word, input int len);
		for (int e = 0; e < len; e++) begin
			case (o)
				VOP_LOAD: model_vrf[d][e] = model_mem[word + e];
				VOP_STORE: begin
					model_mem[word + e] = model_vrf[s2][e];
					exp_adr_q.push_back(MEM_BASE + 32'((word + e) * 4)); // stride 4
					exp_dat_q.push_back(model_vrf[s2][e]);
				end
				VOP_ADD: model_vrf[d][e] = model_vrf[s1][e] + model_vrf[s2][e];
				VOP_SUB: model_vrf[d][e] = model_vrf[s1][e] - model_vrf[s2][e];
				VOP_AND: model_vrf[d][e] = model_vrf[s1][e] & model_vrf[s2][e];
				VOP_OR:  model_vrf[d][e] = model_vrf[s1][e] | model_vrf[s2][e];
				default: model_vrf[d][e] = model_vrf[s1][e] ^ model_vrf[s2][e];
			endcase
		end
	endtask

	task automatic issue(input vcp_op_e o, input int d, input int s1, input int s2,
		input int word, input int len);
		logic taken;
		@(negedge clk);
		valid = 1'b1;
		op    = o;
		vd    = vreg_idx_t'(d);
		vs1   = vreg_idx_t'(s1);
		vs2   = vreg_idx_t'(s2);
		rs1   = MEM_BASE + 32'(word * 4);
		vl    = vlen_t'(len);
		taken = 1'b0;
		while (!taken) begin
			#1;
			taken = ready; // stable until the next rising edge
			@(posedge clk);
			if (!taken) begin
				@(negedge clk);
			end
		end
		exec_model(o, d, s1, s2, word, len); // acceptance order
		issued++;
	endtask

	task automatic issue_alu();
		issue(vcp_op_e'(3'(rand_bits(3) % 5)), int'(rand_bits(3)), int'(rand_bits(3)),
			int'(rand_bits(3)), 0, 4);
	endtask

	task automatic issue_short_store();
		int len;
		len = int'(rand_bits(2) % 3) + 1; // 1 .. 3
		issue(VOP_STORE, 0, 0, int'(rand_bits(3)), rand_word(len), len);
	endtask

	task automatic issue_mixed();
		int pick, len;
		pick = int'(rand_bits(3));
		len  = int'(rand_bits(2)) + 1;
		if (pick == 7) begin
			pick = int'(VOP_LOAD); // no eighth opcode
		end
		issue(vcp_op_e'(3'(pick)), int'(rand_bits(3)), int'(rand_bits(3)),
			int'(rand_bits(3)), rand_word(len), len);
	endtask

	task automatic wait_idle();
		@(negedge clk);
		valid = 1'b0;
		while (done_cnt < issued) begin
			@(negedge clk); // watchdog bounds this
		end
	endtask

	task automatic compare_memory(input string phase);
		for (int i = 0; i < N_WORDS; i++) begin
			check_equal($sformatf("%s mem[%0d]", phase, i), model_mem[i], u_mem.mem_q[i]);
		end
	endtask

	task automatic check_reset();
		repeat (4) begin
			@(negedge clk);
			check_equal("reset ready_o", 32'd1, 32'(ready));
			check_equal("reset wb_cyc_o", 32'd0, 32'(wb_cyc));
			check_equal("reset alu_done_o", 32'd0, 32'(alu_done));
			check_equal("reset lsu_done_o", 32'd0, 32'(lsu_done));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// monitors, sampled mid-cycle
	////////////////////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		if (rstn && alu_done) begin
			done_cnt++;
		end
		if (rstn && lsu_done) begin
			done_cnt++;
		end
	end

	always @(negedge clk) begin
		if (rstn && wb_cyc && wb_stb && wb_we && wb_ack) begin
			if (exp_adr_q.size() == 0) begin
				errors++;
				$display("Wishbone write to %h while the model has no store pending", wb_adr);
			end else begin
				check_equal("wb write address", exp_adr_q.pop_front(), wb_adr);
				check_equal("wb write data", exp_dat_q.pop_front(), wb_dat_m);
			end
		end
	end

	initial begin
		repeat (WD_CYC) @(posedge clk);
		$display("watchdog expired after %0d cycles, %0d of %0d instructions done, errors %0d",
			WD_CYC, done_cnt, issued, errors);
		$display("Test FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		lfsr_q = 32'hdf27;
		valid  = 1'b0;
		op     = VOP_ADD;
		vd     = '0;
		vs1    = '0;
		vs2    = '0;
		rs1    = '0;
		vl     = vlen_t'(4);
		for (int r = 0; r < `VCP_NUM_VREGS; r++) begin
			for (int e = 0; e < `VCP_NUM_ELEMS; e++) begin
				model_vrf[r][e] = '0; // register file resets to zero
			end
		end
		@(posedge rstn);
		for (int i = 0; i < N_WORDS; i++) begin
			model_mem[i] = u_mem.mem_q[i]; // preset image
		end
		check_reset();

		issue(VOP_LOAD, 0, 0, 0, 0, 4); // round trip
		issue(VOP_LOAD, 1, 0, 0, 4, 4);
		issue(VOP_STORE, 0, 0, 0, 32, 4);
		issue(VOP_STORE, 0, 0, 1, 36, 4);
		wait_idle();
		compare_memory("roundtrip");

		for (int i = 0; i < 4; i++) begin
			issue(VOP_LOAD, i, 0, 0, rand_word(4), 4);
		end
		repeat (8) issue_alu();
		for (int i = 0; i < 8; i++) begin
			issue(VOP_STORE, 0, 0, i, i * 8, 4); // dump every register
		end
		wait_idle();
		compare_memory("alu");

		repeat (6) issue_short_store();
		wait_idle();
		compare_memory("short");

		repeat (24) issue_mixed(); // hazards and unit overlap
		wait_idle();
		compare_memory("mix");

		check_equal("done pulse count", 32'(issued), 32'(done_cnt));
		check_equal("pending wb writes", 32'd0, 32'(exp_adr_q.size()));
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== dv/vcp_wb_mem.sv ====
////////////////////////////////////////////////////////////////////////////
// Wishbone classic slave, 64 words decoded from adr[7:2], upper bits ignored
// ack is registered and comes 0 to 3 idle cycles after the strobe
// reset fills every word with a pattern built from its whole index
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "vcp_macros.svh"

module vcp_wb_mem (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	input  logic [`VCP_ADDR_W-1:0] wb_adr_i,
	input  logic [`VCP_DATA_W-1:0] wb_dat_i,
	output logic [`VCP_DATA_W-1:0] wb_dat_o,
	output logic                   wb_ack_o
);

	logic [`VCP_DATA_W-1:0] mem_q [64];
	logic [31:0]            lfsr_q, lfsr_n1, lfsr_n2;
	logic [1:0]             delay, wait_q;
	logic                   armed_q, new_req, give_ack;
	logic [5:0]             word;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	function automatic logic [31:0] fill_word(input int i);
		return 32'(i + 1) * 32'h9e37_79b1; // odd multiplier, full index
	endfunction

	assign lfsr_n1  = lfsr_step(lfsr_q);
	assign lfsr_n2  = lfsr_step(lfsr_n1);
	assign delay    = {lfsr_n1[0], lfsr_n2[0]};      // two bits per request
	assign word     = wb_adr_i[7:2];
	assign new_req  = wb_cyc_i && wb_stb_i && !wb_ack_o && !armed_q;
	assign give_ack = (new_req && delay == 2'd0) || (armed_q && wait_q == 2'd1);

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			for (int i = 0; i < 64; i++) begin
				mem_q[i] <= fill_word(i);
			end
			lfsr_q   <= 32'hdf27;
			armed_q  <= 1'b0;
			wait_q   <= 2'd0;
			wb_ack_o <= 1'b0;
			wb_dat_o <= '0;
		end else begin
			wb_ack_o <= 1'b0; // single-cycle ack
			if (new_req) begin
				lfsr_q  <= lfsr_n2;
				armed_q <= delay != 2'd0;
				wait_q  <= delay;
			end else if (armed_q) begin
				wait_q <= wait_q - 2'd1;
				if (wait_q == 2'd1) begin
					armed_q <= 1'b0;
				end
			end
			if (give_ack) begin
				wb_ack_o <= 1'b1;
				wb_dat_o <= mem_q[word]; // read data with ack
				if (wb_we_i) begin
					mem_q[word] <= wb_dat_i;
				end
			end
		end
	end

endmodule

// ==== dv/vcp_tb_clk.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench clock and reset, 20 ns period
// reset is held low for 3 rising edges and released on a falling edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module vcp_tb_clk (
	output logic clk_o,
	output logic rstn_o
);

	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o; // half of 20 ns
	end

	initial begin
		rstn_o = 1'b0;
		repeat (3) @(posedge clk_o); // 3 cycles in reset
		@(negedge clk_o);
		rstn_o = 1'b1; // away from the sampling edge
	end

endmodule

// ==== source/vcp_top.sv ====
////////////////////////////////////////////////////////////////////////////
// vector co-processor top: controller, ALU, load/store unit, register file
// instruction port is valid/ready, memory port is a Wishbone classic master
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "vcp_macros.svh"

module vcp_top import vcp_pkg::*; (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic                   valid_i,
	input  vcp_op_e                op_i,
	input  vreg_idx_t              vd_i,
	input  vreg_idx_t              vs1_i,
	input  vreg_idx_t              vs2_i,
	input  logic [`VCP_ADDR_W-1:0] rs1_i,
	input  vlen_t                  vl_i,
	output logic                   ready_o,
	output logic                   alu_done_o,
	output logic                   lsu_done_o,
	output logic                   wb_cyc_o,
	output logic                   wb_stb_o,
	output logic                   wb_we_o,
	output logic [`VCP_ADDR_W-1:0] wb_adr_o,
	output logic [`VCP_DATA_W-1:0] wb_dat_o,
	input  logic [`VCP_DATA_W-1:0] wb_dat_i,
	input  logic                   wb_ack_i
);

	// dispatch bus, shared by both units
	logic                   alu_start, lsu_start;
	vcp_op_e                op;
	vreg_idx_t              vd, vs1, vs2;
	logic [`VCP_ADDR_W-1:0] base;
	vlen_t                  vl;

	// register file clients
	logic                   alu_req, alu_we, alu_gnt;
	vreg_idx_t              alu_idx;
	elem_idx_t              alu_elem;
	logic [`VCP_DATA_W-1:0] alu_wdata, alu_rdata;
	logic                   lsu_req, lsu_we, lsu_gnt;
	vreg_idx_t              lsu_idx;
	elem_idx_t              lsu_elem;
	logic [`VCP_DATA_W-1:0] lsu_wdata, lsu_rdata;

	vcp_ctrl u_ctrl (
		.clk_i       (clk_i),
		.rstn_i      (rstn_i),
		.valid_i     (valid_i),
		.op_i        (op_i),
		.vd_i        (vd_i),
		.vs1_i       (vs1_i),
		.vs2_i       (vs2_i),
		.rs1_i       (rs1_i),
		.vl_i        (vl_i),
		.alu_done_i  (alu_done_o),
		.lsu_done_i  (lsu_done_o),
		.ready_o     (ready_o),
		.alu_start_o (alu_start),
		.lsu_start_o (lsu_start),
		.op_o        (op),
		.vd_o        (vd),
		.vs1_o       (vs1),
		.vs2_o       (vs2),
		.base_o      (base),
		.vl_o        (vl)
	);

	vcp_valu u_valu (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.start_i    (alu_start),
		.op_i       (op),
		.vd_i       (vd),
		.vs1_i      (vs1),
		.vs2_i      (vs2),
		.vl_i       (vl),
		.rf_gnt_i   (alu_gnt),
		.rf_rdata_i (alu_rdata),
		.rf_req_o   (alu_req),
		.rf_we_o    (alu_we),
		.rf_idx_o   (alu_idx),
		.rf_elem_o  (alu_elem),
		.rf_wdata_o (alu_wdata),
		.done_o     (alu_done_o)
	);

	vcp_vlsu u_vlsu (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.start_i    (lsu_start),
		.is_store_i (op == VOP_STORE), // op is stable while start is high
		.vd_i       (vd),
		.vs2_i      (vs2),
		.base_i     (base),
		.vl_i       (vl),
		.rf_gnt_i   (lsu_gnt),
		.rf_rdata_i (lsu_rdata),
		.wb_dat_i   (wb_dat_i),
		.wb_ack_i   (wb_ack_i),
		.rf_req_o   (lsu_req),
		.rf_we_o    (lsu_we),
		.rf_idx_o   (lsu_idx),
		.rf_elem_o  (lsu_elem),
		.rf_wdata_o (lsu_wdata),
		.done_o     (lsu_done_o),
		.wb_cyc_o   (wb_cyc_o),
		.wb_stb_o   (wb_stb_o),
		.wb_we_o    (wb_we_o),
		.wb_adr_o   (wb_adr_o),
		.wb_dat_o   (wb_dat_o)
	);

	vcp_vrf u_vrf (
		.clk_i       (clk_i),
		.rstn_i      (rstn_i),
		.alu_req_i   (alu_req),
		.alu_we_i    (alu_we),
		.alu_idx_i   (alu_idx),
		.alu_elem_i  (alu_elem),
		.alu_wdata_i (alu_wdata),
		.alu_gnt_o   (alu_gnt),
		.alu_rdata_o (alu_rdata),
		.lsu_req_i   (lsu_req),
		.lsu_we_i    (lsu_we),
		.lsu_idx_i   (lsu_idx),
		.lsu_elem_i  (lsu_elem),
		.lsu_wdata_i (lsu_wdata),
		.lsu_gnt_o   (lsu_gnt),
		.lsu_rdata_o (lsu_rdata)
	);

endmodule

// ==== source/vcp_vlsu.sv ====
////////////////////////////////////////////////////////////////////////////
// vector load/store unit, Wishbone classic master
// one full-word access per element at base + 4*e, no byte selects
// load: bus read then register write; store: register read then bus write
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "vcp_macros.svh"

module vcp_vlsu import vcp_pkg::*; (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic                   start_i,
	input  logic                   is_store_i,
	input  vreg_idx_t              vd_i,
	input  vreg_idx_t              vs2_i,
	input  logic [`VCP_ADDR_W-1:0] base_i,
	input  vlen_t                  vl_i,
	input  logic                   rf_gnt_i,
	input  logic [`VCP_DATA_W-1:0] rf_rdata_i,
	input  logic [`VCP_DATA_W-1:0] wb_dat_i,
	input  logic                   wb_ack_i,
	output logic                   rf_req_o,
	output logic                   rf_we_o,
	output vreg_idx_t              rf_idx_o,
	output elem_idx_t              rf_elem_o,
	output logic [`VCP_DATA_W-1:0] rf_wdata_o,
	output logic                   done_o,
	output logic                   wb_cyc_o,
	output logic                   wb_stb_o,
	output logic                   wb_we_o,
	output logic [`VCP_ADDR_W-1:0] wb_adr_o,
	output logic [`VCP_DATA_W-1:0] wb_dat_o
);

	vlsu_state_e            state_q;
	elem_idx_t              elem_q;
	logic                   store_q;
	vreg_idx_t              vd_q, vs2_q;
	logic [`VCP_ADDR_W-1:0] base_q;
	vlen_t                  vl_q;
	logic [`VCP_DATA_W-1:0] ld_data_q; // loaded word awaiting register write
	logic                   last;

	assign last = (vlen_t'(elem_q) + vlen_t'(1)) == vl_q;

	////////////////////////////////////////////////////////////////////////////
	// sequencer
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			state_q <= VL_IDLE;
			elem_q  <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state_q)
				VL_IDLE: if (start_i) begin
					elem_q  <= '0;
					state_q <= is_store_i ? VL_RF : VL_WB; // store fetches first
				end
				VL_WB: if (wb_ack_i) begin
					if (!store_q) begin
						state_q <= VL_RF;  // write loaded word back
					end else if (last) begin
						state_q <= VL_IDLE;
						done_o  <= 1'b1;
					end else begin
						elem_q  <= elem_q + 1'b1;
						state_q <= VL_RF;
					end
				end
				VL_RF: if (rf_gnt_i) begin
					if (store_q) begin
						state_q <= VL_WB;  // data valid next cycle
					end else if (last) begin
						state_q <= VL_IDLE;
						done_o  <= 1'b1;
					end else begin
						elem_q  <= elem_q + 1'b1;
						state_q <= VL_WB;
					end
				end
				default: state_q <= VL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == VL_IDLE && start_i) begin
			store_q <= is_store_i;
			vd_q    <= vd_i;
			vs2_q   <= vs2_i;
			base_q  <= base_i;
			vl_q    <= vl_i;
		end
		if (state_q == VL_WB && wb_ack_i) begin
			ld_data_q <= wb_dat_i; // don't care on stores
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// register file and bus outputs
	////////////////////////////////////////////////////////////////////////////
	assign rf_req_o   = state_q == VL_RF;
	assign rf_we_o    = rf_req_o && !store_q;
	assign rf_idx_o   = store_q ? vs2_q : vd_q;
	assign rf_elem_o  = elem_q;
	assign rf_wdata_o = ld_data_q;

	assign wb_cyc_o = state_q == VL_WB;
	assign wb_stb_o = state_q == VL_WB;
	assign wb_we_o  = wb_cyc_o && store_q;
	assign wb_adr_o = base_q + `VCP_ADDR_W'({elem_q, 2'b00}); // stride 4
	assign wb_dat_o = rf_rdata_i; // held by the register file until next read

	// classic cycle: strobe, cycle, address and data hold until ack
	a_wb_hold : assert property (@(posedge clk_i) disable iff (!rstn_i)
		(wb_stb_o && !wb_ack_i) |=>
		(wb_stb_o && wb_cyc_o && $stable(wb_adr_o) && $stable(wb_dat_o)));

endmodule

// ==== source/vcp_valu.sv ====
////////////////////////////////////////////////////////////////////////////
// element-serial integer vector ALU
// three register file accesses per element: read vs1, read vs2, write vd
// arithmetic wraps at DATA_W bits, sub is vs1 - vs2
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "vcp_macros.svh"

module vcp_valu import vcp_pkg::*; (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic                   start_i,
	input  vcp_op_e                op_i,
	input  vreg_idx_t              vd_i,
	input  vreg_idx_t              vs1_i,
	input  vreg_idx_t              vs2_i,
	input  vlen_t                  vl_i,
	input  logic                   rf_gnt_i,
	input  logic [`VCP_DATA_W-1:0] rf_rdata_i,
	output logic                   rf_req_o,
	output logic                   rf_we_o,
	output vreg_idx_t              rf_idx_o,
	output elem_idx_t              rf_elem_o,
	output logic [`VCP_DATA_W-1:0] rf_wdata_o,
	output logic                   done_o
);

	valu_state_e            state_q;
	elem_idx_t              elem_q;
	vcp_op_e                op_q;
	vreg_idx_t              vd_q, vs1_q, vs2_q;
	vlen_t                  vl_q;
	logic [`VCP_DATA_W-1:0] opa_q;   // vs1 element, vs2 stays on rf_rdata_i
	logic                   last;

	assign last = (vlen_t'(elem_q) + vlen_t'(1)) == vl_q;

	////////////////////////////////////////////////////////////////////////////
	// sequencer
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			state_q <= VA_IDLE;
			elem_q  <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0; // one-cycle pulse
			case (state_q)
				VA_IDLE: if (start_i) begin
					state_q <= VA_RD1;
					elem_q  <= '0;
				end
				VA_RD1: if (rf_gnt_i) state_q <= VA_RD2;
				VA_RD2: if (rf_gnt_i) state_q <= VA_WR;
				VA_WR: if (rf_gnt_i) begin
					elem_q <= elem_q + 1'b1;
					if (last) begin
						state_q <= VA_IDLE;
						done_o  <= 1'b1;
					end else begin
						state_q <= VA_RD1;
					end
				end
				default: state_q <= VA_IDLE;
			endcase
		end
	end

	// instruction fields and first operand
	always_ff @(posedge clk_i) begin
		if (state_q == VA_IDLE && start_i) begin
			op_q  <= op_i;
			vd_q  <= vd_i;
			vs1_q <= vs1_i;
			vs2_q <= vs2_i;
			vl_q  <= vl_i;
		end
		if (state_q == VA_RD2 && rf_gnt_i) begin
			opa_q <= rf_rdata_i; // vs1 data, vs2 lands on this edge
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// register file port and datapath
	////////////////////////////////////////////////////////////////////////////
	assign rf_req_o  = state_q != VA_IDLE;
	assign rf_we_o   = state_q == VA_WR;
	assign rf_elem_o = elem_q;

	always_comb begin
		case (state_q)
			VA_RD1:  rf_idx_o = vs1_q;
			VA_RD2:  rf_idx_o = vs2_q;
			default: rf_idx_o = vd_q;
		endcase
	end

	always_comb begin
		case (op_q)
			VOP_ADD: rf_wdata_o = opa_q + rf_rdata_i;
			VOP_SUB: rf_wdata_o = opa_q - rf_rdata_i;
			VOP_AND: rf_wdata_o = opa_q & rf_rdata_i;
			VOP_OR:  rf_wdata_o = opa_q | rf_rdata_i;
			VOP_XOR: rf_wdata_o = opa_q ^ rf_rdata_i;
			default: rf_wdata_o = '0; // memory ops never reach the ALU
		endcase
	end

	// a write waits for its grant with request and result held
	a_we_req : assert property (@(posedge clk_i) disable iff (!rstn_i)
		(rf_we_o && !rf_gnt_i) |=> (rf_we_o && rf_req_o && $stable(rf_wdata_o)));

endmodule

// ==== source/vcp_vrf.sv ====
////////////////////////////////////////////////////////////////////////////
// vector register file, NUM_VREGS x NUM_ELEMS words, one access per cycle
// round-robin between ALU and LSU; a read returns data the next cycle
// and each client's rdata holds until its next granted read
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "vcp_macros.svh"

module vcp_vrf import vcp_pkg::*; (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic                   alu_req_i,
	input  logic                   alu_we_i,
	input  vreg_idx_t              alu_idx_i,
	input  elem_idx_t              alu_elem_i,
	input  logic [`VCP_DATA_W-1:0] alu_wdata_i,
	output logic                   alu_gnt_o,
	output logic [`VCP_DATA_W-1:0] alu_rdata_o,
	input  logic                   lsu_req_i,
	input  logic                   lsu_we_i,
	input  vreg_idx_t              lsu_idx_i,
	input  elem_idx_t              lsu_elem_i,
	input  logic [`VCP_DATA_W-1:0] lsu_wdata_i,
	output logic                   lsu_gnt_o,
	output logic [`VCP_DATA_W-1:0] lsu_rdata_o
);

	logic [`VCP_DATA_W-1:0] regs_q [`VCP_NUM_VREGS][`VCP_NUM_ELEMS];
	logic                   rr_q;    // 1 = LSU has priority on contention
	logic                   wr_en;
	vreg_idx_t              wr_idx;
	elem_idx_t              wr_elem;
	logic [`VCP_DATA_W-1:0] wr_data;

	////////////////////////////////////////////////////////////////////////////
	// arbiter
	////////////////////////////////////////////////////////////////////////////
	assign alu_gnt_o = alu_req_i && (!lsu_req_i || !rr_q);
	assign lsu_gnt_o = lsu_req_i && (!alu_req_i || rr_q);

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			rr_q <= 1'b0;
		end else if (alu_req_i && lsu_req_i) begin
			rr_q <= ~rr_q; // loser goes first next time
		end
	end

	// single write port, fed by whichever client won
	assign wr_en   = (alu_gnt_o && alu_we_i) || (lsu_gnt_o && lsu_we_i);
	assign wr_idx  = lsu_gnt_o ? lsu_idx_i : alu_idx_i;
	assign wr_elem = lsu_gnt_o ? lsu_elem_i : alu_elem_i;
	assign wr_data = lsu_gnt_o ? lsu_wdata_i : alu_wdata_i;

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			for (int r = 0; r < `VCP_NUM_VREGS; r++) begin
				for (int e = 0; e < `VCP_NUM_ELEMS; e++) begin
					regs_q[r][e] <= '0; // all registers start at zero
				end
			end
		end else if (wr_en) begin
			regs_q[wr_idx][wr_elem] <= wr_data;
		end
	end

	// per-client read data, old value on a same-edge write
	always_ff @(posedge clk_i) begin
		if (alu_gnt_o && !alu_we_i) begin
			alu_rdata_o <= regs_q[alu_idx_i][alu_elem_i];
		end
		if (lsu_gnt_o && !lsu_we_i) begin
			lsu_rdata_o <= regs_q[lsu_idx_i][lsu_elem_i];
		end
	end

	// never two grants in one cycle
	a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!rstn_i)
		$onehot0({alu_gnt_o, lsu_gnt_o}));

	// a waiting client keeps its request and target steady
	a_alu_req_hold : assert property (@(posedge clk_i) disable iff (!rstn_i)
		(alu_req_i && !alu_gnt_o) |=>
		(alu_req_i && $stable(alu_idx_i) && $stable(alu_elem_i)));

	a_lsu_req_hold : assert property (@(posedge clk_i) disable iff (!rstn_i)
		(lsu_req_i && !lsu_gnt_o) |=>
		(lsu_req_i && $stable(lsu_idx_i) && $stable(lsu_elem_i)));

endmodule

// ==== source/vcp_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction acceptance, register scoreboard and dispatch
// one instruction in flight per unit; RAW, WAW and WAR hazards stall
// ready_o so that results match in-order execution
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "vcp_macros.svh"

module vcp_ctrl import vcp_pkg::*; (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic                   valid_i,
	input  vcp_op_e                op_i,
	input  vreg_idx_t              vd_i,
	input  vreg_idx_t              vs1_i,
	input  vreg_idx_t              vs2_i,
	input  logic [`VCP_ADDR_W-1:0] rs1_i,
	input  vlen_t                  vl_i,
	input  logic                   alu_done_i,
	input  logic                   lsu_done_i,
	output logic                   ready_o,
	output logic                   alu_start_o,
	output logic                   lsu_start_o,
	output vcp_op_e                op_o,
	output vreg_idx_t              vd_o,
	output vreg_idx_t              vs1_o,
	output vreg_idx_t              vs2_o,
	output logic [`VCP_ADDR_W-1:0] base_o,
	output vlen_t                  vl_o
);

	logic                      is_alu;     // op goes to the ALU
	logic                      accept;     // handshake this cycle
	logic [`VCP_NUM_VREGS-1:0] need;       // registers the new op touches
	logic [`VCP_NUM_VREGS-1:0] alu_regs_q; // held by the running ALU op
	logic [`VCP_NUM_VREGS-1:0] lsu_regs_q; // held by the running LSU op
	logic                      alu_busy_q;
	logic                      lsu_busy_q;

	////////////////////////////////////////////////////////////////////////////
	// decode and hazard check
	////////////////////////////////////////////////////////////////////////////
	assign is_alu = !(op_i == VOP_LOAD || op_i == VOP_STORE);

	always_comb begin
		need = '0;
		case (op_i)
			VOP_LOAD:  need[vd_i]  = 1'b1; // writes vd only
			VOP_STORE: need[vs2_i] = 1'b1; // reads vs2 only
			default: begin
				need[vd_i]  = 1'b1;
				need[vs1_i] = 1'b1;
				need[vs2_i] = 1'b1;
			end
		endcase
	end

	// sources are held too, so a later writer cannot overtake a reader
	assign ready_o = !(is_alu ? alu_busy_q : lsu_busy_q) &&
		!(|(need & (alu_regs_q | lsu_regs_q)));
	assign accept  = valid_i && ready_o;

	////////////////////////////////////////////////////////////////////////////
	// scoreboard and start pulses
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			alu_busy_q  <= 1'b0;
			lsu_busy_q  <= 1'b0;
			alu_regs_q  <= '0;
			lsu_regs_q  <= '0;
			alu_start_o <= 1'b0;
			lsu_start_o <= 1'b0;
		end else begin
			alu_start_o <= accept && is_alu;  // unit starts next cycle
			lsu_start_o <= accept && !is_alu;
			if (accept && is_alu) begin
				alu_busy_q <= 1'b1;
				alu_regs_q <= need;
			end else if (alu_done_i) begin
				alu_busy_q <= 1'b0;
				alu_regs_q <= '0; // release on done
			end
			if (accept && !is_alu) begin
				lsu_busy_q <= 1'b1;
				lsu_regs_q <= need;
			end else if (lsu_done_i) begin
				lsu_busy_q <= 1'b0;
				lsu_regs_q <= '0;
			end
		end
	end

	// dispatch fields, held until the next acceptance
	always_ff @(posedge clk_i) begin
		if (accept) begin
			op_o   <= op_i;
			vd_o   <= vd_i;
			vs1_o  <= vs1_i;
			vs2_o  <= vs2_i;
			base_o <= rs1_i;
			vl_o   <= vl_i;
		end
	end

	// done only for a tracked unit, never on top of a new start
	a_alu_done_busy : assert property (@(posedge clk_i) disable iff (!rstn_i)
		alu_done_i |-> (alu_busy_q && !alu_start_o));

	a_lsu_done_busy : assert property (@(posedge clk_i) disable iff (!rstn_i)
		lsu_done_i |-> (lsu_busy_q && !lsu_start_o));

endmodule

// ==== source/vcp_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// types shared by the co-processor RTL and the testbench
// widths follow the sizing macros, opcode encoding is fixed at 3 bits
////////////////////////////////////////////////////////////////////////////

`include "vcp_macros.svh"

package vcp_pkg;

	// instruction opcodes, five ALU ops then the two memory ops
	typedef enum logic [2:0] {
		VOP_ADD   = 3'd0,
		VOP_SUB   = 3'd1, // vs1 - vs2
		VOP_AND   = 3'd2,
		VOP_OR    = 3'd3,
		VOP_XOR   = 3'd4,
		VOP_LOAD  = 3'd5, // unit stride, writes vd
		VOP_STORE = 3'd6  // unit stride, reads vs2
	} vcp_op_e;

	typedef logic [$clog2(`VCP_NUM_VREGS)-1:0]   vreg_idx_t; // register index
	typedef logic [$clog2(`VCP_NUM_ELEMS+1)-1:0] vlen_t;     // 1 .. NUM_ELEMS
	typedef logic [$clog2(`VCP_NUM_ELEMS)-1:0]   elem_idx_t; // element index

	// ALU sequencer, one pass of rd1/rd2/wr per element
	typedef enum logic [1:0] {
		VA_IDLE,
		VA_RD1,  // fetch vs1 element
		VA_RD2,  // fetch vs2 element
		VA_WR    // write result to vd
	} valu_state_e;

	// load/store sequencer
	typedef enum logic [1:0] {
		VL_IDLE,
		VL_RF,   // register file access
		VL_WB    // Wishbone cycle open
	} vlsu_state_e;

endpackage

// ==== include/vcp_macros.svh ====
////////////////////////////////////////////////////////////////////////////
// sizing of the vector co-processor, shared by package and RTL
// element count must stay a power of two, elem_idx_t is derived from it
// one element is one 32-bit Wishbone word, stride fixed at 4 bytes
////////////////////////////////////////////////////////////////////////////

`ifndef VCP_MACROS_SVH
`define VCP_MACROS_SVH

// architectural vector registers
`define VCP_NUM_VREGS 8

// elements per vector register, also the maximum vl
`define VCP_NUM_ELEMS 4

// element width in bits
`define VCP_DATA_W 32

// Wishbone byte address width
`define VCP_ADDR_W 32

`endif
